// File: filelist.f
design/matmul_pkg.sv
design/operand_sequencer.sv
design/mac_unit.sv
design/result_writer.sv
design/matmul_top.sv
bench/matmul_props.sv
bench/matmul_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = matmul_tb
FILELIST  = filelist.f
SIM_BIN   = obj_dir/V$(TOP)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

// File: bench/matmul_tb.sv
`timescale 1ns/1ps
`default_nettype none

module matmul_tb import matmul_pkg::*; ();

  localparam int MEM_DEPTH  = 1 << ADDR_W;
  localparam int JOB_COUNT  = 10;
  localparam int WAIT_LIMIT = 400;  // Cycles per wait loop

  logic   clk;
  logic   reset_n;
  logic   dut_valid;
  logic   dut_ready;
  addr_t  input_read_address;
  data_t  input_read_data = '0;
  addr_t  weight_read_address;
  data_t  weight_read_data = '0;
  logic   result_write_enable;
  addr_t  result_write_address;
  data_t  result_write_data;

  data_t  input_mem  [0:MEM_DEPTH-1];
  data_t  weight_mem [0:MEM_DEPTH-1];
  data_t  result_mem [0:MEM_DEPTH-1];
  data_t  expected_c [0:MEM_DEPTH-1];  // Row-major model of C
  addr_t  rd_in_addr;
  addr_t  rd_wt_addr;
  integer seed = 32'hc938;
  int     job;
  int     rows_a;
  int     inner;
  int     cols_b;

  matmul_top #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W)
  ) dut0 (
    .clk                  (clk),
    .reset_n              (reset_n),
    .dut_valid            (dut_valid),
    .dut_ready            (dut_ready),
    .input_read_address   (input_read_address),
    .input_read_data      (input_read_data),
    .weight_read_address  (weight_read_address),
    .weight_read_data     (weight_read_data),
    .result_write_enable  (result_write_enable),
    .result_write_address (result_write_address),
    .result_write_data    (result_write_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------
  // SRAM models
  // --------------------
  always @(posedge clk)
  begin
    rd_in_addr = input_read_address;   // Address from the cycle before the edge
    rd_wt_addr = weight_read_address;
    if (result_write_enable)
      result_mem[result_write_address] = result_write_data;
    #1;
    input_read_data  = input_mem[rd_in_addr];
    weight_read_data = weight_mem[rd_wt_addr];
  end

  task automatic fail_stop(input string what);
    begin
      $display("%s", what);
      $display("Done: errors found");
      $fatal(1, "simulation stopped");
    end
  endtask

  task automatic check_data(input string name, input data_t expected, input data_t actual);
    begin
      if (actual !== expected)
        fail_stop($sformatf("error at %0t: %s expected %h, got %h",
                            $time, name, expected, actual));
    end
  endtask

  task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
    begin
      if (actual !== expected)
        fail_stop($sformatf("error at %0t: %s expected %h, got %h",
                            $time, name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    begin
      if (actual !== expected)
        fail_stop($sformatf("error at %0t: %s expected %b, got %b",
                            $time, name, expected, actual));
    end
  endtask

  // Any bound property failure ends the run too
  always @(negedge clk)
  begin
    if (dut0.props0.violation_seen)
      fail_stop("a property on the DUT failed");
  end

  task automatic drive_valid(input logic value);
    begin
      @(posedge clk);
      #1 dut_valid = value;
    end
  endtask

  task automatic wait_ready();
    int cycles;
    begin
      cycles = 0;
      @(negedge clk);
      while (!dut_ready)
      begin
        cycles++;
        if (cycles > WAIT_LIMIT)
          fail_stop("timed out waiting for dut_ready to go high");
        @(negedge clk);
      end
    end
  endtask

  // Fill both SRAMs, place the job and build the expected C
  task automatic load_job(input int m, input int n, input int p);
    mat_dims_t dims_a;
    mat_dims_t dims_b;
    data_t     acc;
    int        i;
    int        j;
    int        k;
    begin
      for (i = 0; i < MEM_DEPTH; i++)
      begin
        input_mem[addr_t'(i)]  = 32'ha000_0000 | i;
        weight_mem[addr_t'(i)] = 32'hb000_0000 | i;
      end
      dims_a.rows = dim_t'(m);
      dims_a.cols = dim_t'(n);
      dims_b.rows = dim_t'(n);
      dims_b.cols = dim_t'(p);
      input_mem[addr_t'(0)]  = dims_a;
      weight_mem[addr_t'(0)] = dims_b;
      for (i = 0; i < m * n; i++)
        input_mem[addr_t'(1 + i)] = $random(seed);
      for (i = 0; i < n * p; i++)
        weight_mem[addr_t'(1 + i)] = $random(seed);  // One column of B after another
      for (i = 0; i < m; i++)
      begin
        for (j = 0; j < p; j++)
        begin
          acc = '0;
          for (k = 0; k < n; k++)
            acc = acc + input_mem[addr_t'(1 + i * n + k)] * weight_mem[addr_t'(1 + j * n + k)];
          expected_c[addr_t'(i * p + j)] = acc;
        end
      end
    end
  endtask

  task automatic run_job(input int count, input logic poke);
    int cycles;
    int seen;
    int i;
    begin
      wait_ready();
      drive_valid(1'b1);
      drive_valid(1'b0);  // Start taken on the edge in between
      cycles = 0;
      seen   = 0;
      while (seen < count)
      begin
        @(negedge clk);
        cycles++;
        if (cycles > WAIT_LIMIT)
          fail_stop("timed out waiting for the result writes of a job");
        check_flag("dut_ready", 1'b0, dut_ready);
        if (result_write_enable)
        begin
          check_addr("result_write_address", addr_t'(seen), result_write_address);
          check_data("result_write_data", expected_c[addr_t'(seen)], result_write_data);
          seen++;
        end
        // A second start request in the middle of the job
        if (poke && cycles == 1)
          drive_valid(1'b1);
        if (poke && cycles == 3)
          drive_valid(1'b0);
      end
      @(negedge clk);
      check_flag("dut_ready", 1'b1, dut_ready);
      check_flag("result_write_enable", 1'b0, result_write_enable);
      for (i = 0; i < count; i++)
        check_data("result_mem", expected_c[addr_t'(i)], result_mem[addr_t'(i)]);
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial
  begin
    reset_n   = 1'b0;
    dut_valid = 1'b0;
    repeat (2) @(posedge clk);
    #1 reset_n = 1'b1;
    @(negedge clk);
    check_flag("dut_ready", 1'b1, dut_ready);
    check_flag("result_write_enable", 1'b0, result_write_enable);

    for (job = 0; job < JOB_COUNT; job++)
    begin
      if (job == 0)
      begin
        rows_a = 1;
        inner  = 1;
        cols_b = 1;
      end
      else if (job == 1)
      begin
        rows_a = 4;
        inner  = 1;
        cols_b = 4;
      end
      else
      begin
        rows_a = 1 + ($unsigned($random(seed)) % 4);
        inner  = 1 + ($unsigned($random(seed)) % 4);
        cols_b = 1 + ($unsigned($random(seed)) % 4);
      end
      load_job(rows_a, inner, cols_b);
      run_job(rows_a * cols_b, (job % 2) == 1);
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/matmul_props.sv
`timescale 1ns/1ps
`default_nettype none

module matmul_props #(
  parameter int ADDR_W = 12
) (
  input logic              clk,
  input logic              reset_n,
  input logic              dut_valid,
  input logic              dut_ready,
  input logic              result_write_enable,
  input logic [ADDR_W-1:0] result_write_address
);

  logic violation_seen = 1'b0;  // Sticky, set by any failing property

  // --------------------
  // Handshake
  // --------------------
  no_write_while_ready: assert property (@(posedge clk) disable iff (!reset_n)
    !(result_write_enable && dut_ready))
  else
  begin
    $error("result write while dut_ready is high");
    violation_seen = 1'b1;
  end

  ready_drops_after_start: assert property (@(posedge clk) disable iff (!reset_n)
    (dut_valid && dut_ready) |=> !dut_ready)
  else
  begin
    $error("dut_ready still high after an accepted start");
    violation_seen = 1'b1;
  end

  write_address_known: assert property (@(posedge clk) disable iff (!reset_n)
    result_write_enable |-> !$isunknown(result_write_address))
  else
  begin
    $error("result_write_address unknown during a write");
    violation_seen = 1'b1;
  end

endmodule

bind matmul_top matmul_props #(
  .ADDR_W (ADDR_W)
) props0 (
  .clk                  (clk),
  .reset_n              (reset_n),
  .dut_valid            (dut_valid),
  .dut_ready            (dut_ready),
  .result_write_enable  (result_write_enable),
  .result_write_address (result_write_address)
);

`default_nettype wire

// File: design/matmul_top.sv
`timescale 1ns/1ps
`default_nettype none

module matmul_top import matmul_pkg::*; #(
  parameter int DATA_W = 32,
  parameter int ADDR_W = 12
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              dut_valid,
  output logic              dut_ready,
  output logic [ADDR_W-1:0] input_read_address,
  input  logic [DATA_W-1:0] input_read_data,
  output logic [ADDR_W-1:0] weight_read_address,
  input  logic [DATA_W-1:0] weight_read_data,
  output logic              result_write_enable,
  output logic [ADDR_W-1:0] result_write_address,
  output logic [DATA_W-1:0] result_write_data
);

  mac_op_t mac_op;
  result_t result;
  logic    job_done;   // Final element written

  // --------------------
  // Sequencer, MAC, writer
  // --------------------
  operand_sequencer #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W)
  ) seq0 (
    .clk                 (clk),
    .reset_n             (reset_n),
    .dut_valid           (dut_valid),
    .dut_ready           (dut_ready),
    .input_read_address  (input_read_address),
    .input_read_data     (input_read_data),
    .weight_read_address (weight_read_address),
    .weight_read_data    (weight_read_data),
    .job_done            (job_done),
    .mac_op              (mac_op)
  );

  mac_unit #(
    .DATA_W (DATA_W)
  ) mac0 (
    .clk     (clk),
    .reset_n (reset_n),
    .mac_op  (mac_op),
    .result  (result)
  );

  result_writer #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W)
  ) wr0 (
    .clk                  (clk),
    .reset_n              (reset_n),
    .result               (result),
    .result_write_enable  (result_write_enable),
    .result_write_address (result_write_address),
    .result_write_data    (result_write_data),
    .job_done             (job_done)
  );

endmodule

`default_nettype wire

// File: design/result_writer.sv
`timescale 1ns/1ps
`default_nettype none

module result_writer import matmul_pkg::*; #(
  parameter int DATA_W = 32,
  parameter int ADDR_W = 12
) (
  input  logic              clk,
  input  logic              reset_n,
  input  result_t           result,
  output logic              result_write_enable,
  output logic [ADDR_W-1:0] result_write_address,
  output logic [DATA_W-1:0] result_write_data,
  output logic              job_done
);

  logic [ADDR_W-1:0] next_addr;  // Row-major slot for the next element

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      result_write_enable <= 1'b0;
      job_done            <= 1'b0;
      next_addr           <= '0;
    end
    else
    begin
      result_write_enable <= result.valid;
      job_done            <= result.valid && result.is_final;
      if (result.valid)
      begin
        // Each job starts again at address 0
        next_addr <= result.is_final ? '0 : next_addr + 1'b1;
      end
    end
    if (result.valid)
    begin
      result_write_address <= next_addr;
      result_write_data    <= result.value;
    end
  end

endmodule

`default_nettype wire

// File: design/mac_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mac_unit import matmul_pkg::*; #(
  parameter int DATA_W = 32
) (
  input  logic    clk,
  input  logic    reset_n,
  input  mac_op_t mac_op,
  output result_t result
);

  logic [DATA_W-1:0] prod_q;   // Stage 1 product, wraps
  mac_tag_t          tag1_q;
  logic [DATA_W-1:0] acc_q;
  logic              res_valid_q;
  logic              res_final_q;

  // --------------------
  // Stage 1 multiply
  // --------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      tag1_q <= '0;
    end
    else
    begin
      tag1_q <= mac_op.tag;
    end
    prod_q <= mac_op.a * mac_op.b;
  end

  // --------------------
  // Stage 2 accumulate
  // --------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      res_valid_q <= 1'b0;
      res_final_q <= 1'b0;
    end
    else
    begin
      res_valid_q <= tag1_q.valid && tag1_q.last;
      res_final_q <= tag1_q.valid && tag1_q.last && tag1_q.is_final;
    end
    if (tag1_q.valid)
      acc_q <= tag1_q.first ? prod_q : acc_q + prod_q;  // Restart per element
  end

  always_comb
  begin
    result.valid    = res_valid_q;
    result.is_final = res_final_q;
    result.value    = acc_q;
  end

endmodule

`default_nettype wire

// File: design/operand_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module operand_sequencer import matmul_pkg::*; #(
  parameter int DATA_W = 32,
  parameter int ADDR_W = 12
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              dut_valid,
  output logic              dut_ready,
  output logic [ADDR_W-1:0] input_read_address,
  input  logic [DATA_W-1:0] input_read_data,
  output logic [ADDR_W-1:0] weight_read_address,
  input  logic [DATA_W-1:0] weight_read_data,
  input  logic              job_done,
  output mac_op_t           mac_op
);

  seq_state_t        state;
  logic              dims_live;   // Word 0 is on the read buses this cycle
  mat_dims_t         dims_a_q;
  mat_dims_t         dims_b_q;
  mat_dims_t         dims_a;
  mat_dims_t         dims_b;
  dim_t              k_idx;       // Term within a dot product
  dim_t              j_idx;       // Column of B
  dim_t              i_idx;       // Row of A
  logic              k_end;
  logic              j_end;
  logic              i_end;
  logic [ADDR_W-1:0] a_addr;
  logic [ADDR_W-1:0] b_addr;
  logic [ADDR_W-1:0] row_base;    // Start of the current row of A
  mac_tag_t          tag_q;

  assign dut_ready = (state == idle);

  // Dimensions come straight off the SRAM in the first run cycle
  always_comb
  begin
    dims_a = dims_live ? mat_dims_t'(input_read_data) : dims_a_q;
    dims_b = dims_live ? mat_dims_t'(weight_read_data) : dims_b_q;
  end

  assign k_end = (k_idx == dims_a.cols - 1'b1);
  assign j_end = (j_idx == dims_b.cols - 1'b1);
  assign i_end = (i_idx == dims_a.rows - 1'b1);

  assign input_read_address  = a_addr;
  assign weight_read_address = b_addr;

  // Tag lags the addresses by one cycle, matching the SRAM read latency
  always_comb
  begin
    mac_op.tag = tag_q;
    mac_op.a   = input_read_data;
    mac_op.b   = weight_read_data;
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state     <= idle;
      dims_live <= 1'b0;
      tag_q     <= '0;
      a_addr    <= '0;
      b_addr    <= '0;
      k_idx     <= '0;
      j_idx     <= '0;
      i_idx     <= '0;
    end
    else
    begin
      dims_live <= 1'b0;
      tag_q     <= '0;
      case (state)
        idle:
        begin
          if (dut_valid)
          begin
            state  <= dims;
            a_addr <= '0;  // Dimension word
            b_addr <= '0;
          end
        end

        dims:
        begin
          state     <= run;
          dims_live <= 1'b1;
          a_addr    <= ADDR_W'(1);
          b_addr    <= ADDR_W'(1);
          row_base  <= ADDR_W'(1);
          k_idx     <= '0;
          j_idx     <= '0;
          i_idx     <= '0;
        end

        run:
        begin
          if (dims_live)
          begin
            dims_a_q <= dims_a;
            dims_b_q <= dims_b;
          end
          tag_q.valid    <= 1'b1;
          tag_q.first    <= (k_idx == '0);
          tag_q.last     <= k_end;
          tag_q.is_final <= k_end && j_end && i_end;

          // --------------------
          // Loop stepping
          // --------------------
          if (!k_end)
          begin
            k_idx  <= k_idx + 1'b1;
            a_addr <= a_addr + 1'b1;
            b_addr <= b_addr + 1'b1;
          end
          else
          begin
            k_idx <= '0;
            if (!j_end)
            begin
              j_idx  <= j_idx + 1'b1;
              a_addr <= row_base;       // Same row, next column of B
              b_addr <= b_addr + 1'b1;
            end
            else
            begin
              j_idx <= '0;
              if (!i_end)
              begin
                i_idx    <= i_idx + 1'b1;
                a_addr   <= a_addr + 1'b1;
                row_base <= a_addr + 1'b1;
                b_addr   <= ADDR_W'(1);  // Back to column 0 of B
              end
              else
              begin
                state <= drain;
              end
            end
          end
        end

        drain:
        begin
          if (job_done)
            state <= idle;
        end

        default: state <= idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/matmul_pkg.sv
`default_nettype none

package matmul_pkg;

  // --------------------
  // Widths
  // --------------------
  parameter int DATA_W = 32;  // SRAM word and accumulator
  parameter int ADDR_W = 12;
  parameter int DIM_W  = 16;  // One half of the dimension word

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DIM_W-1:0]  dim_t;

  // Word 0 of each matrix, rows in the upper half
  typedef struct packed {
    dim_t rows;
    dim_t cols;
  } mat_dims_t;

  // --------------------
  // Pipeline payloads
  // --------------------
  typedef struct packed {
    logic valid;
    logic first;     // Restart the dot product
    logic last;      // Dot product complete after this term
    logic is_final;  // Last term of the whole job
  } mac_tag_t;

  typedef struct packed {
    mac_tag_t tag;
    data_t    a;
    data_t    b;
  } mac_op_t;

  typedef struct packed {
    logic  valid;
    logic  is_final;
    data_t value;
  } result_t;

  typedef enum logic [1:0] {
    idle,
    dims,
    run,
    drain
  } seq_state_t;

endpackage

`default_nettype wire
